// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = icache_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_tag_array.sv
hdl/axi_line_fetch.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
verification/sram_64x128.sv
verification/icache_properties.sv
verification/icache_tb.sv

// ==== hdl/axi_line_fetch.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module axi_line_fetch (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      fetch_start,
    input  logic [31:0]               fetch_addr,
    output logic                      fetch_done,
    output icache_pkg::line_t         fetch_line,
    output logic                      fetch_err,
    output icache_pkg::axi_ar_t       ar,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic                      rvalid,
    input  logic [`ICACHE_BEAT_W-1:0] rdata,
    input  logic [1:0]                rresp,
    input  logic                      rlast,
    output logic                      rready
);
    import icache_pkg::*;

    logic        arvalid_q;
    logic [31:0] araddr_q;
    logic        reading_q;     // address taken, beats still due
    logic        beat_q;
    logic        done_q;
    logic        err_q;
    line_t       line_q;
    logic        ar_fire;
    logic        r_fire;

    assign ar_fire = arvalid_q && arready;
    assign r_fire  = rvalid && reading_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid_q <= 1'b0;
            reading_q <= 1'b0;
            beat_q    <= 1'b0;
            done_q    <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            done_q <= r_fire && rlast;          // one cycle after the last beat
            if (fetch_start) begin
                arvalid_q <= 1'b1;
                beat_q    <= 1'b0;
                err_q     <= 1'b0;
            end else if (ar_fire) begin
                arvalid_q <= 1'b0;
                reading_q <= 1'b1;
            end
            if (r_fire) begin
                beat_q <= ~beat_q;
                if (axi_resp_t'(rresp) != OKAY) err_q <= 1'b1;
                if (rlast) reading_q <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address and line buffer
    always_ff @(posedge clock) begin
        if (fetch_start) begin
            araddr_q <= {fetch_addr[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
        end
        if (r_fire) begin
            line_q[beat_q*`ICACHE_BEAT_W +: `ICACHE_BEAT_W] <= rdata;   // low address first
        end
    end

    assign ar = '{addr:  araddr_q,
                  id:    4'd0,
                  len:   `ICACHE_BURST_LEN,
                  size:  `ICACHE_BURST_SIZE,
                  burst: `AXI_BURST_INCR};

    assign arvalid    = arvalid_q;
    assign rready     = reading_q;
    assign fetch_done = done_q;
    assign fetch_line = line_q;
    assign fetch_err  = err_q;

endmodule

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ctrl (
    input  logic                       clock,
    input  logic                       reset,
    // core side
    input  logic                       req_valid,
    input  icache_pkg::fetch_req_t     req,
    output logic                       req_ready,
    output logic                       rsp_valid,
    output icache_pkg::fetch_rsp_t     rsp,
    input  logic                       rsp_ready,
    // tag array
    output logic [`ICACHE_INDEX_W-1:0] lookup_index,
    output logic [`ICACHE_TAG_W-1:0]   lookup_tag,
    output logic                       touch,
    input  logic                       hit,
    input  logic                       hit_way,
    input  logic                       victim_way,
    output logic                       fill_valid,
    output logic                       fill_way,
    output logic [`ICACHE_TAG_W-1:0]   fill_tag,
    // line fetch
    output logic                       fetch_start,
    output logic [31:0]                fetch_addr,
    input  logic                       fetch_done,
    input  icache_pkg::line_t          fetch_line,
    input  logic                       fetch_err,
    // data arrays, one macro per way
    output logic [`ICACHE_INDEX_W-1:0] io_sram0_addr,
    output logic                       io_sram0_cen,
    output logic                       io_sram0_wen,
    output logic [`ICACHE_LINE_W-1:0]  io_sram0_wmask,
    output logic [`ICACHE_LINE_W-1:0]  io_sram0_wdata,
    input  logic [`ICACHE_LINE_W-1:0]  io_sram0_rdata,
    output logic [`ICACHE_INDEX_W-1:0] io_sram1_addr,
    output logic                       io_sram1_cen,
    output logic                       io_sram1_wen,
    output logic [`ICACHE_LINE_W-1:0]  io_sram1_wmask,
    output logic [`ICACHE_LINE_W-1:0]  io_sram1_wdata,
    input  logic [`ICACHE_LINE_W-1:0]  io_sram1_rdata
);
    import icache_pkg::*;

    localparam int TAG_LSB = `ICACHE_OFFSET_W + `ICACHE_INDEX_W;

    ctrl_state_t                state_q;
    ctrl_state_t                state_d;
    fetch_req_t                 req_q;          // request in flight
    fetch_rsp_t                 rsp_q;
    logic                       victim_q;
    logic                       accept;
    logic                       wr_en;
    logic [`ICACHE_INDEX_W-1:0] sram_index;
    logic [`ICACHE_LINE_W-1:0]  wmask_n;
    line_t                      hit_line;

    function automatic logic [`ICACHE_BEAT_W-1:0] pick_half(line_t line, logic upper);
        return upper ? line[`ICACHE_LINE_W-1 -: `ICACHE_BEAT_W] : line[`ICACHE_BEAT_W-1:0];
    endfunction

    assign req_ready = (state_q == IDLE);
    assign accept    = req_valid && req_ready;
    assign rsp_valid = (state_q == RESPOND);
    assign rsp       = rsp_q;

    assign lookup_index = req_q.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign lookup_tag   = req_q.addr[TAG_LSB +: `ICACHE_TAG_W];
    assign touch        = (state_q == LOOKUP);
    assign fill_valid   = (state_q == FILL);
    assign fill_way     = victim_q;
    assign fill_tag     = lookup_tag;
    assign fetch_start  = (state_q == LOOKUP) && !hit;
    assign fetch_addr   = req_q.addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data arrays, both ways read on accept
    assign wr_en      = (state_q == FILL);
    assign sram_index = wr_en ? lookup_index : req.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign wmask_n    = wr_en ? '0 : '1;

    assign io_sram0_addr  = sram_index;
    assign io_sram0_cen   = !(accept || (wr_en && !victim_q));
    assign io_sram0_wen   = !(wr_en && !victim_q);
    assign io_sram0_wmask = wmask_n;
    assign io_sram0_wdata = fetch_line;
    assign io_sram1_addr  = sram_index;
    assign io_sram1_cen   = !(accept || (wr_en && victim_q));
    assign io_sram1_wen   = !(wr_en && victim_q);
    assign io_sram1_wmask = wmask_n;
    assign io_sram1_wdata = fetch_line;

    assign hit_line = hit_way ? io_sram1_rdata : io_sram0_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fsm
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (accept) state_d = LOOKUP;
            LOOKUP:  state_d = hit ? RESPOND : MISS;
            MISS:    if (fetch_done) state_d = fetch_err ? RESPOND : FILL;  // bad line not kept
            FILL:    state_d = RESPOND;
            RESPOND: if (rsp_ready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= req;
        end
        if (state_q == LOOKUP) begin
            victim_q <= victim_way;
            if (hit) begin
                rsp_q <= '{data: pick_half(hit_line, req_q.addr[`ICACHE_OFFSET_W-1]),
                           err:  1'b0};
            end
        end
        if (state_q == MISS && fetch_done) begin
            // miss data straight from the fill buffer
            rsp_q <= '{data: pick_half(fetch_line, req_q.addr[`ICACHE_OFFSET_W-1]),
                       err:  fetch_err};
        end
    end

endmodule

// ==== hdl/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry, 32-bit byte addresses
`define ICACHE_SETS       64
`define ICACHE_OFFSET_W   4
`define ICACHE_INDEX_W    6
`define ICACHE_TAG_W      22
`define ICACHE_LINE_W     128
`define ICACHE_BEAT_W     64

// one line per AXI4 read burst
`define ICACHE_BURST_LEN  8'd1    // two beats
`define ICACHE_BURST_SIZE 3'd3    // 8 bytes per beat
`define AXI_BURST_INCR    2'd1

`endif

// ==== hdl/icache_pkg.sv ====
`include "icache_defines.svh"

package icache_pkg;

    // core side
    typedef struct packed {
        logic [31:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [`ICACHE_BEAT_W-1:0] data;
        logic                      err;
    } fetch_rsp_t;

    // AXI4 read address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        FILL,
        RESPOND
    } ctrl_state_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        EXOKAY = 2'd1,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } axi_resp_t;

endpackage

// ==== hdl/icache_tag_array.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tag_array (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [`ICACHE_INDEX_W-1:0] lookup_index,
    input  logic [`ICACHE_TAG_W-1:0]   lookup_tag,
    output logic                       hit,
    output logic                       hit_way,
    output logic                       victim_way,
    input  logic                       touch,
    input  logic                       fill_valid,
    input  logic                       fill_way,
    input  logic [`ICACHE_TAG_W-1:0]   fill_tag
);

    logic [`ICACHE_TAG_W-1:0] tag_q [2][`ICACHE_SETS];
    logic [1:0]               valid_q [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]  lru_q;      // per set, the way to evict next
    logic [1:0]               set_valid;
    logic [1:0]               way_hit;

    assign set_valid = valid_q[lookup_index];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = set_valid[w] && (tag_q[w][lookup_index] == lookup_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // an empty way wins over the lru way
    always_comb begin
        if (!set_valid[0]) begin
            victim_way = 1'b0;
        end else if (!set_valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[lookup_index];
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            tag_q[fill_way][lookup_index] <= fill_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= 2'b00;
            end
            lru_q <= '0;
        end else if (fill_valid) begin
            valid_q[lookup_index][fill_way] <= 1'b1;
            lru_q[lookup_index]             <= ~fill_way;
        end else if (touch && hit) begin
            lru_q[lookup_index] <= ~hit_way;    // other way becomes lru
        end
    end

endmodule

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top (
    input  logic                       clock,
    input  logic                       reset,
    // core side
    input  logic                       req_valid,
    input  icache_pkg::fetch_req_t     req,
    output logic                       req_ready,
    output logic                       rsp_valid,
    output icache_pkg::fetch_rsp_t     rsp,
    input  logic                       rsp_ready,
    // AXI4 master
    input  logic                       io_master_awready,
    output logic                       io_master_awvalid,
    output logic [31:0]                io_master_awaddr,
    output logic [3:0]                 io_master_awid,
    output logic [7:0]                 io_master_awlen,
    output logic [2:0]                 io_master_awsize,
    output logic [1:0]                 io_master_awburst,
    input  logic                       io_master_wready,
    output logic                       io_master_wvalid,
    output logic [63:0]                io_master_wdata,
    output logic [7:0]                 io_master_wstrb,
    output logic                       io_master_wlast,
    output logic                       io_master_bready,
    input  logic                       io_master_bvalid,
    input  logic [1:0]                 io_master_bresp,
    input  logic [3:0]                 io_master_bid,
    input  logic                       io_master_arready,
    output logic                       io_master_arvalid,
    output logic [31:0]                io_master_araddr,
    output logic [3:0]                 io_master_arid,
    output logic [7:0]                 io_master_arlen,
    output logic [2:0]                 io_master_arsize,
    output logic [1:0]                 io_master_arburst,
    output logic                       io_master_rready,
    input  logic                       io_master_rvalid,
    input  logic [1:0]                 io_master_rresp,
    input  logic [63:0]                io_master_rdata,
    input  logic                       io_master_rlast,
    input  logic [3:0]                 io_master_rid,
    // data array macros
    output logic [`ICACHE_INDEX_W-1:0] io_sram0_addr,
    output logic                       io_sram0_cen,
    output logic                       io_sram0_wen,
    output logic [`ICACHE_LINE_W-1:0]  io_sram0_wmask,
    output logic [`ICACHE_LINE_W-1:0]  io_sram0_wdata,
    input  logic [`ICACHE_LINE_W-1:0]  io_sram0_rdata,
    output logic [`ICACHE_INDEX_W-1:0] io_sram1_addr,
    output logic                       io_sram1_cen,
    output logic                       io_sram1_wen,
    output logic [`ICACHE_LINE_W-1:0]  io_sram1_wmask,
    output logic [`ICACHE_LINE_W-1:0]  io_sram1_wdata,
    input  logic [`ICACHE_LINE_W-1:0]  io_sram1_rdata
);
    import icache_pkg::*;

    logic [`ICACHE_INDEX_W-1:0] lookup_index;
    logic [`ICACHE_TAG_W-1:0]   lookup_tag;
    logic                       touch;
    logic                       hit;
    logic                       hit_way;
    logic                       victim_way;
    logic                       fill_valid;
    logic                       fill_way;
    logic [`ICACHE_TAG_W-1:0]   fill_tag;
    logic                       fetch_start;
    logic [31:0]                fetch_addr;
    logic                       fetch_done;
    line_t                      fetch_line;
    logic                       fetch_err;
    axi_ar_t                    ar;

    // read-only cache, write channels stay idle
    assign io_master_awvalid = 1'b0;
    assign io_master_awaddr  = '0;
    assign io_master_awid    = '0;
    assign io_master_awlen   = '0;
    assign io_master_awsize  = '0;
    assign io_master_awburst = '0;
    assign io_master_wvalid  = 1'b0;
    assign io_master_wdata   = '0;
    assign io_master_wstrb   = '0;
    assign io_master_wlast   = 1'b0;
    assign io_master_bready  = 1'b1;

    assign io_master_araddr  = ar.addr;
    assign io_master_arid    = ar.id;
    assign io_master_arlen   = ar.len;
    assign io_master_arsize  = ar.size;
    assign io_master_arburst = ar.burst;

    icache_ctrl u_ctrl (.*);

    icache_tag_array u_tags (.*);

    axi_line_fetch u_fetch (
        .clock       (clock),
        .reset       (reset),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .fetch_line  (fetch_line),
        .fetch_err   (fetch_err),
        .ar          (ar),
        .arvalid     (io_master_arvalid),
        .arready     (io_master_arready),
        .rvalid      (io_master_rvalid),
        .rdata       (io_master_rdata),
        .rresp       (io_master_rid == 4'd0 ? io_master_rresp : SLVERR), // foreign id is an error
        .rlast       (io_master_rlast),
        .rready      (io_master_rready)
    );

endmodule

// ==== verification/icache_properties.sv ====
`timescale 1ns/1ps

module icache_properties (
    input logic                   clock,
    input logic                   reset,
    input logic                   req_ready,
    input logic                   rsp_valid,
    input logic                   rsp_ready,
    input icache_pkg::fetch_rsp_t rsp,
    input logic                   io_master_arvalid,
    input logic                   io_master_arready,
    input logic [31:0]            io_master_araddr,
    input logic [7:0]             io_master_arlen,
    input logic [2:0]             io_master_arsize,
    input logic [1:0]             io_master_arburst,
    input logic                   io_sram0_cen,
    input logic                   io_sram1_cen
);

    int unsigned failures = 0;

    ar_holds: assert property (@(posedge clock) disable iff (reset)
        io_master_arvalid && !io_master_arready |=> io_master_arvalid
            && $stable({io_master_araddr, io_master_arlen, io_master_arsize, io_master_arburst}))
        else begin
            failures++;
            $error("arvalid dropped or AR payload changed before arready");
        end

    rsp_holds: assert property (@(posedge clock) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            failures++;
            $error("rsp_valid dropped or response changed before rsp_ready");
        end

    // one request in flight so no new refill while a response waits
    no_ar_in_respond: assert property (@(posedge clock) disable iff (reset)
        rsp_valid |-> !io_master_arvalid)
        else begin
            failures++;
            $error("AR raised while a response is pending");
        end

    no_read_on_refill: assert property (@(posedge clock) disable iff (reset)
        io_master_arvalid && io_master_arready |-> io_sram0_cen && io_sram1_cen)
        else begin
            failures++;
            $error("SRAM enabled in the cycle an AR is accepted");
        end

endmodule

bind icache_top icache_properties u_props (.*);

// ==== verification/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int EVICT_REQS     = 9;
    localparam int RANDOM_REQS    = 40;
    localparam int ERROR_REQS     = 6;
    localparam int TOTAL_REQS     = 3 + EVICT_REQS + RANDOM_REQS + ERROR_REQS;
    localparam int TIMEOUT_CYCLES = TOTAL_REQS * 200 + 20;

    typedef struct packed {
        fetch_rsp_t  rsp;
        logic        miss;
        logic [31:0] cycle;     // acceptance edge
    } expect_t;

    logic clock;
    logic reset;
    logic req_valid;
    fetch_req_t req;
    logic req_ready;
    logic rsp_valid;
    fetch_rsp_t rsp;
    logic rsp_ready;
    logic io_master_awready, io_master_awvalid, io_master_wready, io_master_wvalid;
    logic [31:0] io_master_awaddr, io_master_araddr;
    logic [3:0]  io_master_awid, io_master_bid, io_master_arid, io_master_rid;
    logic [7:0]  io_master_awlen, io_master_wstrb, io_master_arlen;
    logic [2:0]  io_master_awsize, io_master_arsize;
    logic [1:0]  io_master_awburst, io_master_bresp, io_master_arburst, io_master_rresp;
    logic [63:0] io_master_wdata, io_master_rdata;
    logic io_master_wlast, io_master_bready, io_master_bvalid;
    logic io_master_arready, io_master_arvalid;
    logic io_master_rready, io_master_rvalid, io_master_rlast;
    logic [5:0]   io_sram0_addr, io_sram1_addr;
    logic         io_sram0_cen, io_sram0_wen, io_sram1_cen, io_sram1_wen;
    logic [127:0] io_sram0_wmask, io_sram0_wdata, io_sram0_rdata;
    logic [127:0] io_sram1_wmask, io_sram1_wdata, io_sram1_rdata;

    integer      seed = 32'h59d9879d;
    string       test_name = "reset";
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          requests = 0;
    int          responses = 0;
    int          ar_count;
    int          last_ars;
    logic [31:0] cycle;
    logic [31:0] rise_cycle;
    logic        rsp_valid_q;
    logic        outstanding;
    logic [31:0] cur_addr;      // request in flight
    logic        stall_rsp;
    expect_t     pending[$];
    expect_t     head;
    logic        mem_busy;
    logic [31:0] mem_addr;
    logic        mem_beat;
    int          pattern [EVICT_REQS] = '{0, 1, 0, 2, 1, 0, 2, 2, 1};

    // shadow copy of tags, valid and lru bits
    logic [`ICACHE_TAG_W-1:0] shadow_tag [2][`ICACHE_SETS];
    logic [1:0]               shadow_valid [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]  shadow_lru;

    icache_top u_dut (.*);

    sram_64x128 u_sram0 (
        .clock (clock),
        .addr  (io_sram0_addr),
        .cen   (io_sram0_cen),
        .wen   (io_sram0_wen),
        .wmask (io_sram0_wmask),
        .wdata (io_sram0_wdata),
        .rdata (io_sram0_rdata)
    );

    sram_64x128 u_sram1 (
        .clock (clock),
        .addr  (io_sram1_addr),
        .cen   (io_sram1_cen),
        .wen   (io_sram1_wen),
        .wmask (io_sram1_wmask),
        .wdata (io_sram1_wdata),
        .rdata (io_sram1_rdata)
    );

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic is_error_addr(logic [31:0] addr);
        return addr >= 32'h8000_0000;
    endfunction

    // memory holds the address on top and its inverse below
    function automatic logic [63:0] beat_data(logic [31:0] addr);
        return {addr, ~addr};
    endfunction

    function automatic expect_t reference(logic [31:0] addr, logic [31:0] now);
        logic [`ICACHE_INDEX_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic                       way;
        expect_t                    e;
        idx        = addr[9:4];
        tag        = addr[31:10];
        e.cycle    = now;
        e.rsp.err  = is_error_addr(addr);
        e.rsp.data = e.rsp.err ? 64'd0 : beat_data({addr[31:3], 3'b000});
        e.miss     = 1'b1;
        for (int w = 0; w < 2; w++) begin
            if (shadow_valid[idx][w] && shadow_tag[w][idx] == tag) begin
                e.miss          = 1'b0;
                shadow_lru[idx] = (w == 0);     // other way is next out
            end
        end
        if (e.miss && !e.rsp.err) begin
            if (!shadow_valid[idx][0]) begin
                way = 1'b0;
            end else if (!shadow_valid[idx][1]) begin
                way = 1'b1;
            end else begin
                way = shadow_lru[idx];
            end
            shadow_tag[way][idx]   = tag;
            shadow_valid[idx][way] = 1'b1;
            shadow_lru[idx]        = ~way;
        end
        return e;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic send_request(input logic [31:0] addr);
        req_valid <= 1'b1;
        req.addr  <= addr;
        @(posedge clock);
        while (!req_ready) @(posedge clock);
        req_valid <= 1'b0;
        requests++;
        @(posedge clock);
        while (!(rsp_valid && rsp_ready)) @(posedge clock);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        @(posedge clock);
        $display("%s: %0d errors", test_name, errors - test_errors);
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI read slave with random delays
    always @(posedge clock) begin
        if (reset) begin
            io_master_arready <= 1'b0;
            io_master_rvalid  <= 1'b0;
            io_master_rlast   <= 1'b0;
            mem_busy          <= 1'b0;
            ar_count          <= 0;
        end else begin
            io_master_arready <= !mem_busy && (rand32() % 3 != 0);
            if (io_master_arvalid && io_master_arready) begin
                io_master_arready <= 1'b0;
                mem_busy          <= 1'b1;
                mem_addr          <= io_master_araddr;
                mem_beat          <= 1'b0;
                ar_count          <= ar_count + 1;
                check_value("ar", 64'({cur_addr[31:4], 4'h0, 4'd0, 8'd1, 3'd3, 2'd1}),
                            64'({io_master_araddr, io_master_arid, io_master_arlen,
                                 io_master_arsize, io_master_arburst}));
            end
            if (io_master_rvalid && io_master_rready) begin
                io_master_rvalid <= 1'b0;
                mem_beat         <= 1'b1;
                if (io_master_rlast) mem_busy <= 1'b0;
            end else if (mem_busy && !io_master_rvalid && (rand32() % 2 == 0)) begin
                io_master_rvalid <= 1'b1;
                io_master_rlast  <= mem_beat;   // second beat ends the burst
                io_master_rdata  <= is_error_addr(mem_addr) ? 64'd0
                                    : beat_data(mem_addr | {28'd0, mem_beat, 3'b000});
                io_master_rresp  <= is_error_addr(mem_addr) ? SLVERR : OKAY;
            end
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            rsp_ready <= 1'b0;
        end else begin
            rsp_ready <= stall_rsp ? (rand32() % 2 == 0) : 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor and compare
    always @(posedge clock) begin
        if (reset) begin
            cycle       = 0;
            last_ars    = 0;
            outstanding = 1'b0;
            rsp_valid_q = 1'b0;
        end else begin
            cycle = cycle + 1;
            // aw and w held idle with bready high
            check_value("write channels idle", 64'd1,
                        64'({|{io_master_awvalid, io_master_awaddr, io_master_awid,
                               io_master_awlen, io_master_awsize, io_master_awburst,
                               io_master_wvalid, io_master_wdata, io_master_wstrb,
                               io_master_wlast}, io_master_bready}));
            if (outstanding) check_value("req_ready while busy", 64'd0, 64'(req_ready));
            if (rsp_valid && !rsp_valid_q) rise_cycle = cycle;
            rsp_valid_q = rsp_valid;
            if (req_valid && req_ready) begin
                pending.push_back(reference(req.addr, cycle));
                cur_addr    = req.addr;
                outstanding = 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                if (pending.size() == 0) begin
                    report_failure("a response arrived with no request outstanding");
                end else begin
                    head = pending.pop_front();
                    check_value("data", head.rsp.data, rsp.data);
                    check_value("err", 64'(head.rsp.err), 64'(rsp.err));
                    check_value("refills", 64'(head.miss), 64'(ar_count - last_ars));
                    if (!head.miss) begin
                        check_value("hit latency", 64'd2, 64'(rise_cycle - head.cycle));
                    end
                end
                last_ars    = ar_count;
                outstanding = 1'b0;
                responses++;
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT stopped answering", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset             = 1'b1;
        req_valid         = 1'b0;
        req               = '0;
        rsp_ready         = 1'b0;
        stall_rsp         = 1'b0;
        io_master_awready = 1'b0;
        io_master_wready  = 1'b0;
        io_master_bvalid  = 1'b0;
        io_master_bresp   = 2'd0;
        io_master_bid     = 4'd0;
        io_master_arready = 1'b0;
        io_master_rvalid  = 1'b0;
        io_master_rdata   = 64'd0;
        io_master_rresp   = 2'd0;
        io_master_rlast   = 1'b0;
        io_master_rid     = 4'd0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            shadow_valid[s] = 2'b00;
        end
        shadow_lru = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        start_test("cold_miss");
        send_request(32'h0000_1238);
        finish_test();

        start_test("hit_same_line");
        send_request(32'h0000_1230);
        send_request(32'h0000_1238);
        finish_test();

        // three tags in set 4
        start_test("evict_lru");
        for (int i = 0; i < EVICT_REQS; i++) begin
            send_request({20'(pattern[i]), 8'h04, 1'(i % 2), 3'b000});
        end
        finish_test();

        start_test("random_stall");
        stall_rsp <= 1'b1;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            repeat (rand32() % 3) @(posedge clock);
            send_request({18'd0, 2'(rand32() % 4), 6'd0, 2'(rand32() % 4),
                          1'(rand32() % 2), 3'b000});
        end
        stall_rsp <= 1'b0;
        finish_test();

        start_test("error_region");
        send_request(32'h0000_0090);
        send_request(32'h0001_0098);
        send_request(32'h8000_0090);
        send_request(32'h8000_0098);    // not installed so it refills again
        send_request(32'h0000_0098);
        send_request(32'h0001_0090);
        finish_test();

        repeat (2) @(posedge clock);
        test_name = "end of run";
        check_value("response count", 64'(requests), 64'(responses));
        if (u_dut.u_props.failures != 0) report_failure("handshake assertions failed");
        $display("%0d requests, %0d checks, %0d errors", requests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/sram_64x128.sv ====
`timescale 1ns/1ps

module sram_64x128 (
    input  logic         clock,
    input  logic [5:0]   addr,
    input  logic         cen,       // active low
    input  logic         wen,       // active low
    input  logic [127:0] wmask,     // a 0 bit is written
    input  logic [127:0] wdata,
    output logic [127:0] rdata
);

    logic [127:0] mem [64];

    always_ff @(posedge clock) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= (mem[addr] & wmask) | (wdata & ~wmask);
            end else begin
                rdata <= mem[addr];     // read data one cycle later
            end
        end
    end

endmodule
